// File: logic/front_end_pkg.sv
// Shared types and constants for the reduced RV32I fetch and decode front end
package front_end_pkg;

    // ========================================
    // Basic words
    // ========================================

    // Architectural data word and register index
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Every instruction is 32 bits wide, so the sequential step is one word
    localparam xlen_t INSTR_BYTES = 32'd4;

    // ========================================
    // Encodings
    // ========================================

    // Major opcodes of the supported RV32I subset with the low two bits included
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Execution unit that will receive the micro-op
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRU,
        UNIT_LSU,
        UNIT_NONE
    } exu_unit_e;

    // Operation requested from the ALU, or the compare used by the branch unit
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // ========================================
    // Packets
    // ========================================

    // Micro-op handed from the issue slot to the back end
    typedef struct packed {
        exu_unit_e unit;
        alu_op_e   alu_op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        xlen_t     imm;
        logic      imm_valid;
        xlen_t     pc;
        logic      illegal;
    } uop_t;

    // Resolved control transfer, used for both trap entry and branch redirect
    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

// File: logic/fetch_ctrl.sv
// Fetch control FSM that runs the memory req/ack handshake and drops stale responses
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_ack_i,
    input  front_end_pkg::redirect_t trap_i,
    input  front_end_pkg::redirect_t branch_i,
    input  logic                     slot_busy_i,
    output logic                     fetch_req_o,
    output logic                     accept_o,
    output logic                     flush_o
);

    // REQUEST holds req high for the current PC
    // DISCARD holds req high for a request that a redirect made stale
    // RELEASE keeps req low until the memory has dropped ack
    typedef enum logic [1:0] {
        REQUEST,
        RELEASE,
        DISCARD
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   redirect;
    logic   take;

    // Either redirect source flushes the slot and retargets the PC
    assign redirect = trap_i.valid | branch_i.valid;

    // The handshake completes when ack is high and the response has somewhere to go
    // A stale response is thrown away, so it never waits for the issue slot
    assign take = fetch_ack_i & ((state_q == DISCARD) | ((state_q == REQUEST) & ~slot_busy_i));

    always_comb begin
        state_d = state_q;
        case (state_q)
            REQUEST: begin
                if (take) begin
                    state_d = RELEASE;
                end else if (redirect) begin
                    // The memory is still working on the old address
                    state_d = DISCARD;
                end
            end
            DISCARD: begin
                if (take) begin
                    state_d = RELEASE;
                end
            end
            RELEASE: begin
                // The four-phase rule allows no new request while ack is still up
                if (!fetch_ack_i) begin
                    state_d = REQUEST;
                end
            end
            default: begin
                state_d = RELEASE;
            end
        endcase
    end

    // Reset parks the FSM in RELEASE so req stays low during reset
    // and rises on the first edge after release, since ack is low then
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= RELEASE;
        end else begin
            state_q <= state_d;
        end
    end

    // Req is high whenever a request is outstanding, fresh or stale
    assign fetch_req_o = (state_q != RELEASE);

    // A response taken in the same cycle as a redirect belongs to the old path.
    // It still completes the handshake but does not load or advance the PC
    assign accept_o = take & (state_q == REQUEST) & ~redirect;

    assign flush_o = redirect;

endmodule

// File: logic/pc_gen.sv
// Program counter register with trap, branch and sequential next-address selection
`timescale 1ns/1ps

module pc_gen #(
    parameter front_end_pkg::xlen_t RESET_PC = '0
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  front_end_pkg::redirect_t trap_i,
    input  front_end_pkg::redirect_t branch_i,
    input  logic                     accept_i,
    output front_end_pkg::xlen_t     pc_o
);

    front_end_pkg::xlen_t pc_q;
    front_end_pkg::xlen_t pc_d;

    // Priority goes trap entry, then resolved branch, then the step after an accept
    always_comb begin
        if (trap_i.valid) begin
            pc_d = trap_i.target;
        end else if (branch_i.valid) begin
            pc_d = branch_i.target;
        end else if (accept_i) begin
            pc_d = pc_q + front_end_pkg::INSTR_BYTES;
        end else begin
            // Hold the address while the request is still open
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // The fetch address is the current PC itself
    assign pc_o = pc_q;

endmodule

// File: logic/instr_decoder.sv
// Combinational RV32I subset decoder from instruction word and address to micro-op
`timescale 1ns/1ps

module instr_decoder (
    input  front_end_pkg::xlen_t instr_i,
    input  front_end_pkg::xlen_t pc_i,
    output front_end_pkg::uop_t  uop_o
);

    front_end_pkg::opcode_e  opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    front_end_pkg::reg_idx_t rd;
    front_end_pkg::reg_idx_t rs1;
    front_end_pkg::reg_idx_t rs2;
    front_end_pkg::xlen_t    imm_i;
    front_end_pkg::xlen_t    imm_s;
    front_end_pkg::xlen_t    imm_b;
    front_end_pkg::xlen_t    imm_u;
    front_end_pkg::xlen_t    imm_j;
    front_end_pkg::xlen_t    shamt;
    logic                    illegal;

    // ========================================
    // Field extraction
    // ========================================

    assign opcode = front_end_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    // Sign-extended immediates of each format take bit 31 as the sign
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    // A shift carries only its amount while the funct7 bits above it select SRL or SRA
    assign shamt = {27'b0, instr_i[24:20]};

    // ========================================
    // Micro-op build
    // ========================================

    always_comb begin
        // Unused register fields stay at zero for every format
        uop_o        = '0;
        uop_o.pc     = pc_i;
        uop_o.unit   = front_end_pkg::UNIT_ALU;
        uop_o.alu_op = front_end_pkg::ADD;
        // A 16-bit encoding is not supported here
        illegal      = (instr_i[1:0] != 2'b11);
        case (opcode)
            front_end_pkg::OPC_LUI: begin
                uop_o.alu_op    = front_end_pkg::PASS_B;
                uop_o.rd        = rd;
                uop_o.imm       = imm_u;
                uop_o.imm_valid = 1'b1;
            end
            front_end_pkg::OPC_AUIPC: begin
                // The back end adds the immediate to the packet PC
                uop_o.rd        = rd;
                uop_o.imm       = imm_u;
                uop_o.imm_valid = 1'b1;
            end
            front_end_pkg::OPC_JAL: begin
                uop_o.unit      = front_end_pkg::UNIT_BRU;
                uop_o.rd        = rd;
                uop_o.imm       = imm_j;
                uop_o.imm_valid = 1'b1;
            end
            front_end_pkg::OPC_BRANCH: begin
                uop_o.unit      = front_end_pkg::UNIT_BRU;
                uop_o.rs1       = rs1;
                uop_o.rs2       = rs2;
                uop_o.imm       = imm_b;
                uop_o.imm_valid = 1'b1;
                // Equality uses a subtract, ordering uses a signed or unsigned compare
                case (funct3)
                    3'b000, 3'b001: uop_o.alu_op = front_end_pkg::SUB;
                    3'b100, 3'b101: uop_o.alu_op = front_end_pkg::SLT;
                    3'b110, 3'b111: uop_o.alu_op = front_end_pkg::SLTU;
                    default:        illegal      = 1'b1;
                endcase
            end
            front_end_pkg::OPC_LOAD: begin
                uop_o.unit      = front_end_pkg::UNIT_LSU;
                uop_o.rd        = rd;
                uop_o.rs1       = rs1;
                uop_o.imm       = imm_i;
                uop_o.imm_valid = 1'b1;
                // LB, LH, LW, LBU and LHU only
                if (funct3 == 3'b011 || funct3[2:1] == 2'b11) begin
                    illegal = 1'b1;
                end
            end
            front_end_pkg::OPC_STORE: begin
                uop_o.unit      = front_end_pkg::UNIT_LSU;
                uop_o.rs1       = rs1;
                uop_o.rs2       = rs2;
                uop_o.imm       = imm_s;
                uop_o.imm_valid = 1'b1;
                if (funct3[2] || funct3 == 3'b011) begin
                    illegal = 1'b1;
                end
            end
            front_end_pkg::OPC_OP_IMM: begin
                uop_o.rd        = rd;
                uop_o.rs1       = rs1;
                uop_o.imm       = imm_i;
                uop_o.imm_valid = 1'b1;
                case (funct3)
                    3'b000: uop_o.alu_op = front_end_pkg::ADD;
                    3'b010: uop_o.alu_op = front_end_pkg::SLT;
                    3'b011: uop_o.alu_op = front_end_pkg::SLTU;
                    3'b100: uop_o.alu_op = front_end_pkg::XOR;
                    3'b110: uop_o.alu_op = front_end_pkg::OR;
                    3'b111: uop_o.alu_op = front_end_pkg::AND;
                    3'b001: begin
                        uop_o.alu_op = front_end_pkg::SLL;
                        uop_o.imm    = shamt;
                        illegal      = (funct7 != 7'b0000000);
                    end
                    default: begin
                        uop_o.imm    = shamt;
                        uop_o.alu_op = funct7[5] ? front_end_pkg::SRA : front_end_pkg::SRL;
                        illegal      = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            front_end_pkg::OPC_OP: begin
                uop_o.rd  = rd;
                uop_o.rs1 = rs1;
                uop_o.rs2 = rs2;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: uop_o.alu_op = front_end_pkg::ADD;
                    {7'b0100000, 3'b000}: uop_o.alu_op = front_end_pkg::SUB;
                    {7'b0000000, 3'b001}: uop_o.alu_op = front_end_pkg::SLL;
                    {7'b0000000, 3'b010}: uop_o.alu_op = front_end_pkg::SLT;
                    {7'b0000000, 3'b011}: uop_o.alu_op = front_end_pkg::SLTU;
                    {7'b0000000, 3'b100}: uop_o.alu_op = front_end_pkg::XOR;
                    {7'b0000000, 3'b101}: uop_o.alu_op = front_end_pkg::SRL;
                    {7'b0100000, 3'b101}: uop_o.alu_op = front_end_pkg::SRA;
                    {7'b0000000, 3'b110}: uop_o.alu_op = front_end_pkg::OR;
                    {7'b0000000, 3'b111}: uop_o.alu_op = front_end_pkg::AND;
                    default:              illegal      = 1'b1;
                endcase
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
        // An illegal word keeps only its PC so the back end can raise the trap
        if (illegal) begin
            uop_o         = '0;
            uop_o.pc      = pc_i;
            uop_o.unit    = front_end_pkg::UNIT_NONE;
            uop_o.alu_op  = front_end_pkg::ADD;
            uop_o.illegal = 1'b1;
        end
    end

endmodule

// File: logic/issue_slot.sv
// Issue slot that holds one micro-op under back-end stall and drops it on a redirect
`timescale 1ns/1ps

module issue_slot (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                load_i,
    input  logic                flush_i,
    input  logic                stall_i,
    input  front_end_pkg::uop_t uop_i,
    output logic                issue_valid_o,
    output front_end_pkg::uop_t issue_uop_o
);

    logic                valid_q;
    front_end_pkg::uop_t uop_q;

    // Flush wins over a load, and a load refills the slot in the same edge it drains
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (valid_q && !stall_i) begin
            // Consumed by the back end with nothing new behind it
            valid_q <= 1'b0;
        end
    end

    // The fetch FSM only loads when the slot is free, so a stalled packet never changes
    always_ff @(posedge clk_i) begin
        if (load_i && !flush_i) begin
            uop_q <= uop_i;
        end
    end

    assign issue_valid_o = valid_q;
    assign issue_uop_o   = uop_q;

endmodule

// File: logic/front_end_top.sv
// Front end top level joining fetch control, PC generation, decode and the issue slot
`timescale 1ns/1ps

module front_end_top #(
    parameter front_end_pkg::xlen_t RESET_PC = '0
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    output logic                     fetch_req_o,
    output front_end_pkg::xlen_t     fetch_addr_o,
    input  logic                     fetch_ack_i,
    input  front_end_pkg::xlen_t     fetch_rdata_i,
    input  front_end_pkg::redirect_t trap_i,
    input  front_end_pkg::redirect_t branch_i,
    input  logic                     stall_i,
    output logic                     issue_valid_o,
    output front_end_pkg::uop_t      issue_uop_o
);

    // ========================================
    // Internal nets
    // ========================================

    // Fresh response taken this cycle
    logic                accept;
    // Redirect seen this cycle
    logic                flush;
    // Decode of the word currently on the memory bus
    front_end_pkg::uop_t decoded_uop;

    // ========================================
    // Control
    // ========================================

    // The slot is busy only if its packet will not leave at this edge
    fetch_ctrl u_fetch_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fetch_ack_i (fetch_ack_i),
        .trap_i      (trap_i),
        .branch_i    (branch_i),
        .slot_busy_i (issue_valid_o & stall_i),
        .fetch_req_o (fetch_req_o),
        .accept_o    (accept),
        .flush_o     (flush)
    );

    // ========================================
    // Datapath
    // ========================================

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .trap_i   (trap_i),
        .branch_i (branch_i),
        .accept_i (accept),
        .pc_o     (fetch_addr_o)
    );

    // The PC has not moved yet when the response arrives, so it tags the packet
    instr_decoder u_instr_decoder (
        .instr_i (fetch_rdata_i),
        .pc_i    (fetch_addr_o),
        .uop_o   (decoded_uop)
    );

    issue_slot u_issue_slot (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (accept),
        .flush_i       (flush),
        .stall_i       (stall_i),
        .uop_i         (decoded_uop),
        .issue_valid_o (issue_valid_o),
        .issue_uop_o   (issue_uop_o)
    );

endmodule

// File: bench/tb_program.svh
// Program image, expected micro-op fields and redirect schedule for the front end testbench
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ========================================
// Program rows
// ========================================

// One row per word address
// Columns are instr, unit, alu_op, rd, rs1, rs2, imm, imm_valid, illegal
typedef struct packed {
    front_end_pkg::xlen_t     instr;
    front_end_pkg::exu_unit_e unit;
    front_end_pkg::alu_op_e   alu_op;
    front_end_pkg::reg_idx_t  rd;
    front_end_pkg::reg_idx_t  rs1;
    front_end_pkg::reg_idx_t  rs2;
    front_end_pkg::xlen_t     imm;
    logic                     imm_valid;
    logic                     illegal;
} prog_row_t;

// Trap and branch inputs applied together in one cycle
typedef struct packed {
    front_end_pkg::redirect_t trap;
    front_end_pkg::redirect_t branch;
} redirect_pair_t;

// Sixteen words of program where anything above reads back as an illegal fill word
localparam front_end_pkg::xlen_t PROGRAM_BYTES = 32'h40;

// Flow 0x00 to 0x14, branch to 0x24, 0x24 to 0x2C, trap to 0x10, then 0x10 to 0x3C
localparam int NUM_TESTS = 21;

function automatic prog_row_t program_row(input logic [3:0] idx);
    prog_row_t row;
    row = '0;
    case (idx)
        // U-type, LUI and AUIPC with a negative upper immediate
        4'h0: row = '{32'h123452B7, front_end_pkg::UNIT_ALU, front_end_pkg::PASS_B,
                      5'd5, 5'd0, 5'd0, 32'h12345000, 1'b1, 1'b0};
        4'h1: row = '{32'hFFFFF317, front_end_pkg::UNIT_ALU, front_end_pkg::ADD,
                      5'd6, 5'd0, 5'd0, 32'hFFFFF000, 1'b1, 1'b0};
        // I-type ADDI x1, x2, -1
        4'h2: row = '{32'hFFF10093, front_end_pkg::UNIT_ALU, front_end_pkg::ADD,
                      5'd1, 5'd2, 5'd0, 32'hFFFFFFFF, 1'b1, 1'b0};
        // S-type SW x7, -4(x3)
        4'h3: row = '{32'hFE71AE23, front_end_pkg::UNIT_LSU, front_end_pkg::ADD,
                      5'd0, 5'd3, 5'd7, 32'hFFFFFFFC, 1'b1, 1'b0};
        // B-type BEQ forward and BLT backward
        4'h4: row = '{32'h00208863, front_end_pkg::UNIT_BRU, front_end_pkg::SUB,
                      5'd0, 5'd1, 5'd2, 32'h00000010, 1'b1, 1'b0};
        4'h5: row = '{32'hFE524CE3, front_end_pkg::UNIT_BRU, front_end_pkg::SLT,
                      5'd0, 5'd4, 5'd5, 32'hFFFFFFF8, 1'b1, 1'b0};
        // J-type JAL x1, +2048
        4'h6: row = '{32'h001000EF, front_end_pkg::UNIT_BRU, front_end_pkg::ADD,
                      5'd1, 5'd0, 5'd0, 32'h00000800, 1'b1, 1'b0};
        4'h7: row = '{32'h00C4A403, front_end_pkg::UNIT_LSU, front_end_pkg::ADD,
                      5'd8, 5'd9, 5'd0, 32'h0000000C, 1'b1, 1'b0};
        // Unknown major opcode
        4'h8: row = '{32'h0000007F, front_end_pkg::UNIT_NONE, front_end_pkg::ADD,
                      5'd0, 5'd0, 5'd0, 32'h00000000, 1'b0, 1'b1};
        4'h9: row = '{32'h40C58533, front_end_pkg::UNIT_ALU, front_end_pkg::SUB,
                      5'd10, 5'd11, 5'd12, 32'h00000000, 1'b0, 1'b0};
        // Low two bits are 00, so this is not a 32-bit encoding
        4'hA: row = '{32'h12345670, front_end_pkg::UNIT_NONE, front_end_pkg::ADD,
                      5'd0, 5'd0, 5'd0, 32'h00000000, 1'b0, 1'b1};
        4'hB: row = '{32'h40775693, front_end_pkg::UNIT_ALU, front_end_pkg::SRA,
                      5'd13, 5'd14, 5'd0, 32'h00000007, 1'b1, 1'b0};
        4'hC: row = '{32'h7FF84793, front_end_pkg::UNIT_ALU, front_end_pkg::XOR,
                      5'd15, 5'd16, 5'd0, 32'h000007FF, 1'b1, 1'b0};
        4'hD: row = '{32'h011902A3, front_end_pkg::UNIT_LSU, front_end_pkg::ADD,
                      5'd0, 5'd18, 5'd17, 32'h00000005, 1'b1, 1'b0};
        4'hE: row = '{32'h015A39B3, front_end_pkg::UNIT_ALU, front_end_pkg::SLTU,
                      5'd19, 5'd20, 5'd21, 32'h00000000, 1'b0, 1'b0};
        // BGEU with the most negative branch offset
        4'hF: row = '{32'h817B7063, front_end_pkg::UNIT_BRU, front_end_pkg::SLTU,
                      5'd0, 5'd22, 5'd23, 32'hFFFFF000, 1'b1, 1'b0};
        default: row = '0;
    endcase
    return row;
endfunction

// ========================================
// Redirect events
// ========================================

// Keyed by the number of packets consumed so far
function automatic redirect_pair_t redirect_after(input int count);
    redirect_pair_t pair;
    pair = '0;
    case (count)
        6: pair = '{'{1'b0, 32'h00000000}, '{1'b1, 32'h00000024}};
        // With both valid the trap target must win
        9: pair = '{'{1'b1, 32'h00000010}, '{1'b1, 32'h00000034}};
        default: pair = '0;
    endcase
    return pair;
endfunction

`endif

// File: bench/tb_front_end.sv
// Testbench for the front end with a random-latency memory, random stall and redirects
`timescale 1ns/1ps

module tb_front_end;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_TEST = 40;
    localparam front_end_pkg::xlen_t START_PC  = 32'h0;
    localparam front_end_pkg::xlen_t STEP      = 32'd4;

    `include "tb_program.svh"

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_ACK
    } mem_state_e;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     fetch_req_o;
    front_end_pkg::xlen_t     fetch_addr_o;
    logic                     fetch_ack_i;
    front_end_pkg::xlen_t     fetch_rdata_i;
    front_end_pkg::redirect_t trap_i;
    front_end_pkg::redirect_t branch_i;
    logic                     stall_i;
    logic                     issue_valid_o;
    front_end_pkg::uop_t      issue_uop_o;

    // Values held from the last falling edge, which the DUT also sees at the next rising edge
    logic                     h_req;
    logic                     h_ack;
    logic                     h_valid;
    logic                     h_stall;
    logic                     h_redirect;
    front_end_pkg::xlen_t     h_addr;
    front_end_pkg::uop_t      h_uop;

    logic [15:0]              lfsr;
    mem_state_e               mem_state;
    front_end_pkg::xlen_t     mem_addr;
    int                       mem_wait;
    front_end_pkg::xlen_t     expected_pc;
    redirect_pair_t           pending;
    int                       tests;
    int                       errors;

    front_end_top #(
        .RESET_PC (START_PC)
    ) UUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_req_o   (fetch_req_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_ack_i   (fetch_ack_i),
        .fetch_rdata_i (fetch_rdata_i),
        .trap_i        (trap_i),
        .branch_i      (branch_i),
        .stall_i       (stall_i),
        .issue_valid_o (issue_valid_o),
        .issue_uop_o   (issue_uop_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // ========================================
    // Random bits and memory model
    // ========================================

    // Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic draw_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic front_end_pkg::xlen_t memory_word(input front_end_pkg::xlen_t addr);
        prog_row_t row;
        row = program_row(addr[5:2]);
        if (addr < PROGRAM_BYTES) begin
            return row.instr;
        end else begin
            // Past the program the word is illegal and carries its own address
            return {addr[31:2], 2'b00};
        end
    endfunction

    task automatic answer_request();
        fetch_ack_i   <= 1'b1;
        fetch_rdata_i <= memory_word(mem_addr);
        mem_state = MEM_ACK;
    endtask

    // Answers 0 to 3 cycles after req is seen, then holds ack until req drops
    task automatic run_memory();
        int delay;
        case (mem_state)
            MEM_IDLE: begin
                if (h_req && !fetch_ack_i) begin
                    draw_bits(2, delay);
                    mem_addr = h_addr;
                    if (delay == 0) begin
                        answer_request();
                    end else begin
                        mem_wait  = delay;
                        mem_state = MEM_WAIT;
                    end
                end
            end
            MEM_WAIT: begin
                mem_wait = mem_wait - 1;
                if (mem_wait == 0) begin
                    answer_request();
                end
            end
            default: begin
                if (!h_req) begin
                    fetch_ack_i <= 1'b0;
                    mem_state = MEM_IDLE;
                end
            end
        endcase
    endtask

    // ========================================
    // Back end and checks
    // ========================================

    // Compares a consumed packet with the table row for the PC the model expects
    task automatic check_packet();
        prog_row_t           row;
        front_end_pkg::uop_t want;
        string               name;
        row            = program_row(expected_pc[5:2]);
        want.unit      = row.unit;
        want.alu_op    = row.alu_op;
        want.rd        = row.rd;
        want.rs1       = row.rs1;
        want.rs2       = row.rs2;
        want.imm       = row.imm;
        want.imm_valid = row.imm_valid;
        want.pc        = expected_pc;
        want.illegal   = row.illegal;
        tests = tests + 1;
        name  = $sformatf("packet %0d at pc %h", tests, expected_pc);
        if (h_uop !== want) begin
            errors = errors + 1;
            $display("Error: %s expected %h actual %h", name, want, h_uop);
        end else begin
            $display("%s ok", name);
        end
        expected_pc = expected_pc + STEP;
        pending     = redirect_after(tests);
    endtask

    // A redirect goes out with stall high so no packet leaves in that cycle
    task automatic drive_backend();
        int bit_val;
        if (pending.trap.valid || pending.branch.valid) begin
            trap_i   <= pending.trap;
            branch_i <= pending.branch;
            stall_i  <= 1'b1;
            pending = '0;
        end else begin
            draw_bits(1, bit_val);
            trap_i   <= '0;
            branch_i <= '0;
            stall_i  <= (bit_val != 0);
        end
    endtask

    // Protocol checks on values that settled after the last rising edge
    always @(negedge clk_i) begin
        if (fetch_req_o && !h_req && h_ack) begin
            errors = errors + 1;
            $display("Request rose at %0t while the memory still held ack", $time);
        end
        if (h_valid && h_stall && !h_redirect) begin
            if (!issue_valid_o || issue_uop_o !== h_uop) begin
                errors = errors + 1;
                $display("Issue packet changed under stall at %0t", $time);
            end
        end
        h_req      = fetch_req_o;
        h_ack      = fetch_ack_i;
        h_valid    = issue_valid_o;
        h_stall    = stall_i;
        h_redirect = trap_i.valid | branch_i.valid;
        h_addr     = fetch_addr_o;
        h_uop      = issue_uop_o;
    end

    initial begin
        rst_n_i       = 1'b0;
        fetch_ack_i   = 1'b0;
        fetch_rdata_i = '0;
        trap_i        = '0;
        branch_i      = '0;
        stall_i       = 1'b0;
        h_req         = 1'b0;
        h_ack         = 1'b0;
        h_valid       = 1'b0;
        h_stall       = 1'b0;
        h_redirect    = 1'b0;
        h_addr        = '0;
        h_uop         = '0;
        lfsr          = 16'd76;
        mem_state     = MEM_IDLE;
        mem_addr      = '0;
        mem_wait      = 0;
        expected_pc   = START_PC;
        pending       = '0;
        tests         = 0;
        errors        = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        while (tests < NUM_TESTS) begin
            @(posedge clk_i);
            run_memory();
            // Trap wins over branch as in the PC rule
            if (trap_i.valid || branch_i.valid) begin
                expected_pc = trap_i.valid ? trap_i.target : branch_i.target;
            end else if (h_valid && !stall_i) begin
                check_packet();
            end
            drive_backend();
        end
        $display("Summary: %0d packets checked, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS));
        $display("Watchdog expired with %0d of %0d packets consumed", tests, NUM_TESTS);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+bench
logic/front_end_pkg.sv
logic/fetch_ctrl.sv
logic/pc_gen.sv
logic/instr_decoder.sv
logic/issue_slot.sv
logic/front_end_top.sv
bench/tb_front_end.sv

// File: run.sh
#!/bin/sh
# Build the front end testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_front_end -o tb_front_end
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_front_end > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
